//--- fetch_frontend.f
+incdir+.
fetch_pkg.sv
fetch_fifo.sv
branch_predictor.sv
fetch_requester.sv
fetch_frontend.sv
tb_fetch_frontend.sv

//--- run.sh
#!/bin/sh
# compile and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_fetch_frontend \
    -f fetch_frontend.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/Vtb_fetch_frontend)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

//--- tb_fetch_frontend.sv
// --------------------------------------------------------------------------
// testbench for the fetch front end: clock, reset, instruction memory model,
// random decode consumer with a reference PC, stimulus and checks
// --------------------------------------------------------------------------

`include "fetch_macros.svh"

module tb_fetch_frontend;

    localparam logic [`FETCH_ADDR_W-1:0] BOOT_PC       = `FETCH_BOOT_ADDR;
    localparam logic [`FETCH_ADDR_W-1:0] ERR_ADDR      = 64'h090;
    localparam logic [`FETCH_ADDR_W-1:0] JAL_ADDR      = 64'h0A0;
    localparam logic [`FETCH_ADDR_W-1:0] JAL_TARGET    = 64'h0C0;
    localparam logic [`FETCH_ADDR_W-1:0] BEQ_ADDR      = 64'h0D0;
    localparam logic [`FETCH_ADDR_W-1:0] BEQ_TARGET    = 64'h0C8;
    localparam logic [`FETCH_ADDR_W-1:0] REDIRECT_PC   = 64'h200;
    localparam logic [`FETCH_ADDR_W-1:0] MISALIGNED_PC = 64'h302;
    localparam logic [`FETCH_ADDR_W-1:0] RESUME_PC     = 64'h100;

    // selectors for the consumer counters that the stimulus waits on
    localparam int SEL_POPS  = 0;
    localparam int SEL_JAL   = 1;
    localparam int SEL_BEQ   = 2;
    localparam int SEL_FAULT = 3;
    localparam int SEL_MIS   = 4;

    logic                     clk_i;
    logic                     rst_ni        = 1'b1;
    logic                     flush_i       = 1'b0;
    logic [`FETCH_ADDR_W-1:0] redirect_pc_i = '0;
    logic                     fetch_req_o;
    logic [`FETCH_ADDR_W-1:0] fetch_addr_o;
    logic                     instr_valid_i = 1'b0;
    logic [31:0]              instr_rdata_i = '0;
    logic                     instr_err_i   = 1'b0;
    fetch_pkg::fetch_entry_t  fetch_entry_0_o;
    logic                     fetch_entry_valid_0_o;
    logic                     fetch_ack_0_i = 1'b0;
    fetch_pkg::fetch_entry_t  fetch_entry_1_o;
    logic                     fetch_entry_valid_1_o;
    logic                     fetch_ack_1_i = 1'b0;

    logic [31:0]              prog [256];
    logic [`FETCH_ADDR_W-1:0] exp_pc;
    logic [31:0]              rng   = 32'd95856;
    logic                     hold  = 1'b0;
    logic                     aborted = 1'b0;
    string                    cur_test = "reset";
    int pops = 0;
    int jal_hits = 0;
    int beq_hits = 0;
    int fault_hits = 0;
    int mis_hits = 0;
    // stimulus side and clocked checker side keep their own error counts
    int stim_errors = 0;
    int chk_errors = 0;
    int test_errs0 = 0;
    int tests_run = 0;
    int tests_failed = 0;

    fetch_frontend dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------------------
    // program image and memory model
    // ----------------------------------------------------------------------
    function automatic logic [31:0] j_word(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, fetch_pkg::OPC_JAL};
    endfunction

    // beq x0, x0 with the given offset
    function automatic logic [31:0] b_word(input logic [12:0] imm);
        return {imm[12], imm[10:5], 10'd0, 3'b000, imm[4:1], imm[11], fetch_pkg::OPC_BRANCH};
    endfunction

    initial begin
        // addi x1, x0, <own address>, so every word is unique
        for (int i = 0; i < 256; i++) begin
            prog[i] = {12'(i * 4), 5'd0, 3'b000, 5'd1, 7'b001_0011};
        end
        prog[JAL_ADDR[9:2]] = j_word(21'(JAL_TARGET - JAL_ADDR));
        prog[BEQ_ADDR[9:2]] = b_word(13'(BEQ_TARGET - BEQ_ADDR));
    end

    // answers every request exactly one cycle later
    always @(posedge clk_i) begin
        instr_valid_i <= fetch_req_o;
        instr_rdata_i <= fetch_req_o ? prog[fetch_addr_o[9:2]] : 32'h0;
        instr_err_i   <= fetch_req_o && (fetch_addr_o == ERR_ADDR);
    end

    // ----------------------------------------------------------------------
    // reference model and decode consumer
    // ----------------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // entry that the front end must deliver for a fetch at addr
    function automatic fetch_pkg::fetch_entry_t expected_entry(
        input logic [`FETCH_ADDR_W-1:0] addr);
        fetch_pkg::fetch_entry_t e;
        e = '0;
        e.address = addr;
        if (addr[1]) begin
            // never sent to memory, zero word and no prediction
            e.ex.valid = 1'b1;
            e.ex.cause = fetch_pkg::CAUSE_INSTR_MISALIGNED;
            e.ex.tval  = addr;
        end else begin
            e.instr = prog[addr[9:2]];
            if (addr == JAL_ADDR) begin
                e.bp = '{taken: 1'b1, valid: 1'b1, target: JAL_TARGET};
            end
            // backward branch, predicted taken
            if (addr == BEQ_ADDR) begin
                e.bp = '{taken: 1'b1, valid: 1'b1, target: BEQ_TARGET};
            end
            if (addr == ERR_ADDR) begin
                e.ex.valid = 1'b1;
                e.ex.cause = fetch_pkg::CAUSE_INSTR_ACCESS_FAULT;
                e.ex.tval  = addr;
            end
        end
        return e;
    endfunction

    task automatic check_entry(input fetch_pkg::fetch_entry_t act);
        fetch_pkg::fetch_entry_t exp_e;
        exp_e = expected_entry(act.address);
        assert (act.address == exp_pc) else begin
            $display("** Error [%s] entry order: expected %h, actual %h",
                     cur_test, exp_pc, act.address);
            chk_errors++;
        end
        assert (act == exp_e) else begin
            $display("** Error [%s] entry at %h: expected %h, actual %h",
                     cur_test, act.address, exp_e, act);
            chk_errors++;
        end
        // follow the actual stream so one slip does not cascade
        exp_pc = exp_e.bp.taken ? exp_e.bp.target : act.address + 64'd4;
        pops++;
        jal_hits   += int'(act.address == JAL_ADDR);
        beq_hits   += int'(act.address == BEQ_ADDR);
        fault_hits += int'(act.address == ERR_ADDR);
        mis_hits   += int'(act.address[1]);
    endtask

    always @(posedge clk_i) begin : decode_consumer
        int avail;
        int pick;
        if (!rst_ni) begin
            fetch_ack_0_i <= 1'b0;
            fetch_ack_1_i <= 1'b0;
            exp_pc = BOOT_PC;
        end else begin
            // entries acked in the cycle that ends now, port 0 first
            if (fetch_ack_0_i) begin
                check_entry(fetch_entry_0_o);
            end
            if (fetch_ack_1_i) begin
                check_entry(fetch_entry_1_o);
            end
            if (flush_i) begin
                exp_pc = redirect_pc_i;
            end
            // lower bound of what stays valid after this edge
            avail = fetch_entry_valid_1_o ? 2 : (fetch_entry_valid_0_o ? 1 : 0);
            avail = avail - int'(fetch_ack_0_i) - int'(fetch_ack_1_i);
            if (flush_i || hold) begin
                avail = 0;
            end
            rng  = xorshift(rng);
            pick = int'(rng % 32'd3);
            if (pick > avail) begin
                pick = avail;
            end
            fetch_ack_0_i <= (pick >= 1);
            fetch_ack_1_i <= (pick >= 2);
        end
    end

    // ----------------------------------------------------------------------
    // concurrent checks
    // ----------------------------------------------------------------------
    assert property (@(posedge clk_i)
        !rst_ni |-> !fetch_req_o && !fetch_entry_valid_0_o && !fetch_entry_valid_1_o)
        else begin
            $display("[%s] request or valid output high during reset", cur_test);
            chk_errors++;
        end

    assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !fetch_req_o && !fetch_entry_valid_0_o && !fetch_entry_valid_1_o)
        else begin
            $display("[%s] request or valid output high right after reset", cur_test);
            chk_errors++;
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> !fetch_entry_valid_0_o && !fetch_entry_valid_1_o)
        else begin
            $display("[%s] FIFO still valid in the cycle after a flush", cur_test);
            chk_errors++;
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni) !dut.fifo_ready |-> !fetch_req_o)
        else begin
            $display("[%s] fetch request issued while the FIFO was not ready", cur_test);
            chk_errors++;
        end

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    function automatic int count_of(input int sel);
        case (sel)
            SEL_POPS:  return pops;
            SEL_JAL:   return jal_hits;
            SEL_BEQ:   return beq_hits;
            SEL_FAULT: return fault_hits;
            default:   return mis_hits;
        endcase
    endfunction

    task automatic wait_count(input int sel, input int target, input int limit,
                              input string what);
        int n;
        n = 0;
        while (count_of(sel) < target && n < limit) begin
            @(posedge clk_i);
            n++;
        end
        if (count_of(sel) < target) begin
            $display("[%s] timeout after %0d cycles waiting for %s", cur_test, limit, what);
            stim_errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic flush_to(input logic [`FETCH_ADDR_W-1:0] pc);
        @(posedge clk_i);
        flush_i       <= 1'b1;
        redirect_pc_i <= pc;
        @(posedge clk_i);
        flush_i       <= 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test   = name;
        test_errs0 = stim_errors + chk_errors;
    endtask

    task automatic end_test();
        int errs;
        errs = stim_errors + chk_errors - test_errs0;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
            $display("test %-16s failed, %0d errors", cur_test, errs);
        end else begin
            $display("test %-16s passed", cur_test);
        end
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin : stimulus
        int n;
        start_test("reset");
        rst_ni <= 1'b0;
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;
        n = 0;
        // outputs are sampled between edges where they are settled
        @(negedge clk_i);
        while (!fetch_req_o && n < 20) begin
            @(negedge clk_i);
            n++;
        end
        if (!fetch_req_o) begin
            $display("[%s] timeout waiting for the first fetch request", cur_test);
            stim_errors++;
            aborted = 1'b1;
        end else begin
            assert (fetch_addr_o == BOOT_PC) else begin
                $display("** Error [%s] first request: expected %h, actual %h",
                         cur_test, BOOT_PC, fetch_addr_o);
                stim_errors++;
            end
        end
        end_test();

        if (!aborted) begin
            start_test("order_and_fault");
            wait_count(SEL_FAULT, 1, 200, "the access fault entry");
            wait_count(SEL_POPS, 6, 200, "sequential entries");
            end_test();
        end
        if (!aborted) begin
            start_test("predict");
            wait_count(SEL_JAL, 1, 200, "the jal entry");
            wait_count(SEL_BEQ, 2, 200, "two passes of the backward branch");
            end_test();
        end
        if (!aborted) begin
            start_test("backpressure");
            hold <= 1'b1;
            repeat (20) @(posedge clk_i);
            @(negedge clk_i);
            assert (fetch_entry_valid_1_o && !fetch_req_o) else begin
                $display("[%s] FIFO did not fill or requests went on while stalled",
                         cur_test);
                stim_errors++;
            end
            @(posedge clk_i);
            hold <= 1'b0;
            wait_count(SEL_POPS, pops + 12, 200, "entries after the stall");
            end_test();
        end
        if (!aborted) begin
            start_test("flush_redirect");
            flush_to(REDIRECT_PC);
            wait_count(SEL_POPS, pops + 10, 200, "entries after the redirect");
            end_test();
        end
        if (!aborted) begin
            start_test("misaligned");
            flush_to(MISALIGNED_PC);
            wait_count(SEL_MIS, 3, 200, "misaligned entries");
            flush_to(RESUME_PC);
            wait_count(SEL_POPS, pops + 6, 200, "entries after the aligned redirect");
            end_test();
        end

        $display("%0d tests run, %0d failed, %0d errors in total",
                 tests_run, tests_failed, stim_errors + chk_errors);
        if (stim_errors + chk_errors == 0 && !aborted) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- fetch_frontend.sv
// --------------------------------------------------------------------------
// fetch front end top: requester, static predictor and dual-port FIFO
// --------------------------------------------------------------------------

`include "fetch_macros.svh"

module fetch_frontend (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // steering from the branch unit
    input  logic                     flush_i,
    input  logic [`FETCH_ADDR_W-1:0] redirect_pc_i,
    // instruction memory
    output logic                     fetch_req_o,
    output logic [`FETCH_ADDR_W-1:0] fetch_addr_o,
    input  logic                     instr_valid_i,
    input  logic [31:0]              instr_rdata_i,
    input  logic                     instr_err_i,
    // decode port 0
    output fetch_pkg::fetch_entry_t  fetch_entry_0_o,
    output logic                     fetch_entry_valid_0_o,
    input  logic                     fetch_ack_0_i,
    // decode port 1
    output fetch_pkg::fetch_entry_t  fetch_entry_1_o,
    output logic                     fetch_entry_valid_1_o,
    input  logic                     fetch_ack_1_i
);

    fetch_pkg::branchpredict_t predict;
    fetch_pkg::fetch_entry_t   entry;
    logic                      entry_valid;
    logic                      fifo_ready;
    logic [`FETCH_ADDR_W-1:0]  resp_addr;
    logic [31:0]               resp_rdata;

    fetch_requester i_fetch_requester (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .redirect_pc_i (redirect_pc_i),
        .fifo_ready_i  (fifo_ready),
        .instr_valid_i (instr_valid_i),
        .instr_rdata_i (instr_rdata_i),
        .instr_err_i   (instr_err_i),
        .predict_i     (predict),
        .fetch_req_o   (fetch_req_o),
        .fetch_addr_o  (fetch_addr_o),
        .resp_addr_o   (resp_addr),
        .resp_rdata_o  (resp_rdata),
        .entry_o       (entry),
        .entry_valid_o (entry_valid)
    );

    // entry_valid marks a live response, killed ones are not predicted on
    branch_predictor i_branch_predictor (
        .resp_valid_i (entry_valid),
        .resp_addr_i  (resp_addr),
        .resp_rdata_i (resp_rdata),
        .predict_o    (predict)
    );

    fetch_fifo i_fetch_fifo (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .in_entry_i            (entry),
        .in_valid_i            (entry_valid),
        .in_ready_o            (fifo_ready),
        .fetch_entry_0_o       (fetch_entry_0_o),
        .fetch_entry_valid_0_o (fetch_entry_valid_0_o),
        .fetch_ack_0_i         (fetch_ack_0_i),
        .fetch_entry_1_o       (fetch_entry_1_o),
        .fetch_entry_valid_1_o (fetch_entry_valid_1_o),
        .fetch_ack_1_i         (fetch_ack_1_i)
    );

endmodule

//--- fetch_requester.sv
// --------------------------------------------------------------------------
// fetch requester: PC register, request issue, flush and predicted
// redirect, kill of stale responses and the fetch exception field
// --------------------------------------------------------------------------

`include "fetch_macros.svh"

module fetch_requester (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  logic [`FETCH_ADDR_W-1:0]  redirect_pc_i,
    input  logic                      fifo_ready_i,
    // memory response, one cycle after the request
    input  logic                      instr_valid_i,
    input  logic [31:0]               instr_rdata_i,
    input  logic                      instr_err_i,
    input  fetch_pkg::branchpredict_t predict_i,
    // memory request
    output logic                      fetch_req_o,
    output logic [`FETCH_ADDR_W-1:0]  fetch_addr_o,
    // response toward the predictor
    output logic [`FETCH_ADDR_W-1:0]  resp_addr_o,
    output logic [31:0]               resp_rdata_o,
    // annotated entry toward the FIFO
    output fetch_pkg::fetch_entry_t   entry_o,
    output logic                      entry_valid_o
);

    logic [`FETCH_ADDR_W-1:0] pc_q, pc_n;
    logic [`FETCH_ADDR_W-1:0] addr_q;
    logic                     run_q;
    logic                     pend_q;
    logic                     mis_q;
    logic                     kill_q, kill_n;
    logic                     issue;
    logic                     redirect;

    // first request one cycle after reset release
    assign issue = run_q & fifo_ready_i;

    // a misaligned PC becomes a local pseudo request, never a memory access
    assign fetch_req_o  = issue & ~pc_q[1];
    assign fetch_addr_o = pc_q;

    // ----------------------------------------------------------------------
    // response cycle
    // ----------------------------------------------------------------------
    assign entry_valid_o = pend_q & ~kill_q & (mis_q | instr_valid_i);
    assign resp_addr_o   = addr_q;
    assign resp_rdata_o  = mis_q ? 32'h0 : instr_rdata_i;

    // follow a taken prediction, the sequential request sent now is stale
    assign redirect = entry_valid_o & predict_i.taken;
    assign kill_n   = issue & (flush_i | redirect);

    always_comb begin
        entry_o         = '0;
        entry_o.address = addr_q;
        entry_o.instr   = resp_rdata_o;
        entry_o.bp      = predict_i;
        // misaligned first, it never reached memory
        if (mis_q) begin
            entry_o.ex.valid = 1'b1;
            entry_o.ex.cause = fetch_pkg::CAUSE_INSTR_MISALIGNED;
            entry_o.ex.tval  = addr_q;
        end else if (instr_err_i) begin
            entry_o.ex.valid = 1'b1;
            entry_o.ex.cause = fetch_pkg::CAUSE_INSTR_ACCESS_FAULT;
            entry_o.ex.tval  = addr_q;
        end
    end

    // ----------------------------------------------------------------------
    // PC and in-flight tracking
    // ----------------------------------------------------------------------
    always_comb begin
        pc_n = pc_q;
        if (flush_i) begin
            pc_n = redirect_pc_i;
        end else if (redirect) begin
            pc_n = predict_i.target;
        end else if (issue) begin
            pc_n = pc_q + `FETCH_ADDR_W'(4);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            run_q  <= 1'b0;
            pc_q   <= `FETCH_BOOT_ADDR;
            pend_q <= 1'b0;
            mis_q  <= 1'b0;
            kill_q <= 1'b0;
        end else begin
            run_q  <= 1'b1;
            pc_q   <= pc_n;
            pend_q <= issue;
            mis_q  <= issue & pc_q[1];
            kill_q <= kill_n;
        end
    end

    // address of the request in flight
    always_ff @(posedge clk_i) begin
        if (issue) begin
            addr_q <= pc_q;
        end
    end

    // memory answers only to a request of the previous cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_valid_i |-> $past(fetch_req_o))
        else $error("instruction response without a request");

endmodule

//--- branch_predictor.sv
// --------------------------------------------------------------------------
// static branch predictor: jal always taken, conditional branches taken
// when backward, targets from the J and B immediates
// --------------------------------------------------------------------------

`include "fetch_macros.svh"

module branch_predictor (
    input  logic                      resp_valid_i,
    input  logic [`FETCH_ADDR_W-1:0]  resp_addr_i,
    input  logic [31:0]               resp_rdata_i,
    output fetch_pkg::branchpredict_t predict_o
);

    logic [6:0]               opcode;
    logic                     is_jal;
    logic                     is_branch;
    logic [`FETCH_ADDR_W-1:0] j_imm;
    logic [`FETCH_ADDR_W-1:0] b_imm;

    assign opcode = resp_rdata_i[6:0];

    // only a live response is decoded
    assign is_jal    = resp_valid_i && (opcode == fetch_pkg::OPC_JAL);
    assign is_branch = resp_valid_i && (opcode == fetch_pkg::OPC_BRANCH);

    // J-immediate, imm[20|10:1|11|19:12] sign extended
    assign j_imm = {{(`FETCH_ADDR_W - 20){resp_rdata_i[31]}},
                    resp_rdata_i[19:12],
                    resp_rdata_i[20],
                    resp_rdata_i[30:21],
                    1'b0};

    // B-immediate, imm[12|10:5] and imm[4:1|11] sign extended
    assign b_imm = {{(`FETCH_ADDR_W - 12){resp_rdata_i[31]}},
                    resp_rdata_i[7],
                    resp_rdata_i[30:25],
                    resp_rdata_i[11:8],
                    1'b0};

    always_comb begin
        predict_o = '0;
        if (is_jal) begin
            // unconditional, always follow
            predict_o.valid  = 1'b1;
            predict_o.taken  = 1'b1;
            predict_o.target = resp_addr_i + j_imm;
        end else if (is_branch) begin
            // backward means a loop, sign bit of the offset decides
            predict_o.valid  = 1'b1;
            predict_o.taken  = resp_rdata_i[31];
            predict_o.target = resp_addr_i + b_imm;
        end
    end

    // a taken prediction only comes from a decoded control-flow word
    always_comb begin
        assert (!predict_o.taken || predict_o.valid)
            else $error("taken prediction on a word that is not a jump or branch");
    end

endmodule

//--- fetch_fifo.sv
// --------------------------------------------------------------------------
// dual-port fetch FIFO: one write per cycle, up to two reads per cycle,
// ready threshold toward the requester and synchronous flush
// --------------------------------------------------------------------------

`include "fetch_macros.svh"

module fetch_fifo (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // empties the FIFO at the next edge
    input  logic                    flush_i,
    // write side
    input  fetch_pkg::fetch_entry_t in_entry_i,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    // read port 0, the oldest entry
    output fetch_pkg::fetch_entry_t fetch_entry_0_o,
    output logic                    fetch_entry_valid_0_o,
    input  logic                    fetch_ack_0_i,
    // read port 1, the entry after port 0
    output fetch_pkg::fetch_entry_t fetch_entry_1_o,
    output logic                    fetch_entry_valid_1_o,
    input  logic                    fetch_ack_1_i
);

    localparam int unsigned DEPTH = `FETCH_FIFO_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    // one bit more so that a count of DEPTH fits
    localparam int unsigned CNT_W = PTR_W + 1;

    fetch_pkg::fetch_entry_t mem_q [DEPTH];

    logic [PTR_W-1:0] rd_ptr_q, rd_ptr_n;
    logic [PTR_W-1:0] rd_ptr_1;
    logic [PTR_W-1:0] wr_ptr_q, wr_ptr_n;
    logic [CNT_W-1:0] cnt_q, cnt_n;
    logic [1:0]       pop_cnt;
    logic             full;

    // entries leaving this cycle, zero, one or two
    assign pop_cnt = {1'b0, fetch_ack_0_i} + {1'b0, fetch_ack_1_i};

    assign full = (cnt_q == CNT_W'(DEPTH));

    // leave room for the response still in flight behind the last request
    assign in_ready_o = (cnt_q < CNT_W'(DEPTH - 2));

    // ----------------------------------------------------------------------
    // read ports
    // ----------------------------------------------------------------------
    // pointer wraps naturally at DEPTH
    assign rd_ptr_1 = rd_ptr_q + PTR_W'(1);

    assign fetch_entry_valid_0_o = (cnt_q >= CNT_W'(1));
    assign fetch_entry_valid_1_o = (cnt_q >= CNT_W'(2));
    assign fetch_entry_0_o       = mem_q[rd_ptr_q];
    assign fetch_entry_1_o       = mem_q[rd_ptr_1];

    // ----------------------------------------------------------------------
    // pointer and counter update
    // ----------------------------------------------------------------------
    always_comb begin
        wr_ptr_n = wr_ptr_q + PTR_W'(in_valid_i);
        rd_ptr_n = rd_ptr_q + PTR_W'(pop_cnt);
        cnt_n    = cnt_q + CNT_W'(in_valid_i) - CNT_W'(pop_cnt);
        // flush wins over a write or read in the same cycle
        if (flush_i) begin
            wr_ptr_n = '0;
            rd_ptr_n = '0;
            cnt_n    = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_n;
            wr_ptr_q <= wr_ptr_n;
            cnt_q    <= cnt_n;
        end
    end

    // storage, a write during flush lands in a slot that is then discarded
    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            mem_q[wr_ptr_q] <= in_entry_i;
        end
    end

    // ----------------------------------------------------------------------
    // assertions
    // ----------------------------------------------------------------------
    // the requester stops at the ready threshold, so a write never meets full
    assert property (@(posedge clk_i) disable iff (!rst_ni) in_valid_i |-> !full)
        else $error("fetch FIFO written while full");

    // decode only takes what is offered
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fetch_ack_0_i |-> fetch_entry_valid_0_o) and
        (fetch_ack_1_i |-> fetch_entry_valid_1_o))
        else $error("fetch FIFO acked on a port that is not valid");

    // port 1 is only ever taken in order behind port 0
    assert property (@(posedge clk_i) disable iff (!rst_ni) fetch_ack_1_i |-> fetch_ack_0_i)
        else $error("fetch FIFO ack on port 1 without port 0");

endmodule

//--- fetch_pkg.sv
// --------------------------------------------------------------------------
// fetch front end types: exception record, static branch prediction,
// fetch FIFO entry, exception cause codes and control-flow opcodes
// --------------------------------------------------------------------------

`include "fetch_macros.svh"

package fetch_pkg;

    // exception cause codes carried in the fetch entry
    localparam logic [3:0] CAUSE_INSTR_MISALIGNED   = 4'd0;
    localparam logic [3:0] CAUSE_INSTR_ACCESS_FAULT = 4'd1;

    // major opcodes of the instructions the predictor follows
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

    // fetch exception, tval holds the faulting fetch address
    typedef struct packed {
        logic                     valid;
        logic [3:0]               cause;
        logic [`FETCH_ADDR_W-1:0] tval;
    } exception_t;

    // prediction attached to every fetched word
    // valid marks a control-flow instruction, taken the predicted direction
    typedef struct packed {
        logic                     taken;
        logic                     valid;
        logic [`FETCH_ADDR_W-1:0] target;
    } branchpredict_t;

    // one fetch FIFO entry as seen by decode
    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] address;
        logic [31:0]              instr;
        branchpredict_t           bp;
        exception_t               ex;
    } fetch_entry_t;

endpackage

//--- fetch_macros.svh
// --------------------------------------------------------------------------
// fetch front end build constants: address width, fetch FIFO depth and the
// PC taken after reset
// --------------------------------------------------------------------------

`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// width of every fetch address and of the PC
`define FETCH_ADDR_W 64

// fetch FIFO entries, must be a power of two
`define FETCH_FIFO_DEPTH 4

// first fetch address after reset
`define FETCH_BOOT_ADDR 64'h0000_0000_0000_0080

`endif
